// File: hw/ppu_pkg.sv
package ppu_pkg;

    // ------------------------------------------------
    // VGA 640x480 timing, in 25 MHz clocks and lines
    // ------------------------------------------------
    localparam logic [9:0] HZ_BACK    = 10'd48;
    localparam logic [9:0] HZ_VISIBLE = 10'd640;
    localparam logic [9:0] HZ_FRONT   = 10'd16;
    localparam logic [9:0] HZ_SYNC    = 10'd96;
    localparam logic [9:0] HZ_WHOLE   = HZ_BACK + HZ_VISIBLE + HZ_FRONT + HZ_SYNC;

    localparam logic [9:0] VT_BACK    = 10'd33;
    localparam logic [9:0] VT_VISIBLE = 10'd480;
    localparam logic [9:0] VT_FRONT   = 10'd10;
    localparam logic [9:0] VT_SYNC    = 10'd2;
    localparam logic [9:0] VT_WHOLE   = VT_BACK + VT_VISIBLE + VT_FRONT + VT_SYNC;

    // PPU raster, one dot per 2x2 VGA pixels
    localparam logic [8:0] PPU_LINE     = 9'd341;
    localparam logic [8:0] PPU_LINES    = 9'd262;
    localparam logic [8:0] PAPER_X0     = 9'd32;
    localparam logic [8:0] PAPER_Y0     = 9'd16;
    localparam logic [8:0] VBL_LINE     = PAPER_Y0 + 9'd241;
    localparam logic [8:0] VBL_END_LINE = PAPER_Y0;     // Top of paper ends vblank
    localparam logic [1:0] CPU_DIV      = 2'd3;         // PPU ticks per CPU cycle

    // Paper is 256 dots = 512 VGA pixels wide
    localparam logic [9:0] BORDER_X0 = HZ_BACK + {PAPER_X0, 1'b0};
    localparam logic [9:0] BORDER_X1 = BORDER_X0 + 10'd512;

    // ------------------------------------------------
    // CPU side
    // ------------------------------------------------
    typedef enum logic [2:0] {
        REG_CTRL, REG_MASK, REG_STATUS, REG_OAMADDR,
        REG_OAMDATA, REG_SCROLL, REG_ADDR, REG_DATA
    } ppu_reg_e;

    localparam logic [15:0] JOY1_ADDR = 16'h4016;   // Also the strobe latch
    localparam logic [15:0] JOY2_ADDR = 16'h4017;

    // ------------------------------------------------
    // Colour types and tables
    // ------------------------------------------------
    typedef logic [5:0] color_idx_t;
    typedef logic [13:0] vram_addr_t;
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Start palette, background then sprites
    localparam color_idx_t PAL_START [32] = '{
        6'h0F, 6'h16, 6'h30, 6'h38, 6'h00, 6'h16, 6'h26, 6'h07,
        6'h00, 6'h26, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10,
        6'h0F, 6'h16, 6'h27, 6'h12, 6'h0F, 6'h30, 6'h2B, 6'h16,
        6'h0F, 6'h39, 6'h28, 6'h27, 6'h0F, 6'h30, 6'h30, 6'h30
    };

    // 64-colour master table, 4 bits per gun
    localparam rgb_t COLOR_LUT [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

endpackage

// File: hw/cpu_bus_if.sv
interface cpu_bus_if;

    logic [15:0] addr;      // Held between ce_cpu pulses
    logic [7:0]  wdata;
    logic        we;
    logic        rd;
    logic        phase_req; // Writes land here
    logic        phase_rsp; // Read data captured here
    logic        pad_sel;   // Joypad claims this read
    logic [7:0]  pad_q;

    // Register file side
    modport slave (
        input addr, wdata, we, rd, phase_req, phase_rsp, pad_sel, pad_q
    );

    // Joypad side, answers $4016/$4017
    modport pad (
        input  addr, wdata, we, rd, phase_req, phase_rsp,
        output pad_sel, pad_q
    );

endinterface

// File: hw/palette_if.sv
interface palette_if;

    logic [4:0]          idx;   // Raw entry, mirroring done in the RAM
    ppu_pkg::color_idx_t wdata;
    logic                we;
    ppu_pkg::color_idx_t rdata;

    modport master (
        output idx, wdata, we,
        input  rdata
    );

    modport slave (
        input  idx, wdata, we,
        output rdata
    );

endinterface

// File: hw/beam_timing.sv
module beam_timing (
    input  logic       clock25,
    input  logic       reset_n,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       visible_o,
    output logic       border_o,
    output logic       ppu_tick_o,
    output logic [8:0] px_o,
    output logic [8:0] py_o,
    output logic       ce_cpu_o,
    output logic       phase_req_o,
    output logic       phase_rsp_o
);

    logic [9:0] x;          // VGA column
    logic [9:0] y;          // VGA line
    logic [1:0] phase;      // 0 = ce_cpu, 1 = request, 2 = response

    wire x_last = (x == ppu_pkg::HZ_WHOLE - 10'd1);
    wire y_last = (y == ppu_pkg::VT_WHOLE - 10'd1);
    wire vis_x  = x >= ppu_pkg::HZ_BACK && x < ppu_pkg::HZ_BACK + ppu_pkg::HZ_VISIBLE;
    wire vis_y  = y >= ppu_pkg::VT_BACK && y < ppu_pkg::VT_BACK + ppu_pkg::VT_VISIBLE;

    // One PPU dot on each odd x of odd lines
    wire tick = x[0] && y[0] && x >= ppu_pkg::HZ_BACK
             && x < ppu_pkg::HZ_BACK + {ppu_pkg::PPU_LINE, 1'b0};

    // Sync pulses are active low
    assign hsync_o   = x < ppu_pkg::HZ_BACK + ppu_pkg::HZ_VISIBLE + ppu_pkg::HZ_FRONT;
    assign vsync_o   = y < ppu_pkg::VT_BACK + ppu_pkg::VT_VISIBLE + ppu_pkg::VT_FRONT;
    assign visible_o = vis_x && vis_y;
    assign border_o  = visible_o && (x < ppu_pkg::BORDER_X0 || x >= ppu_pkg::BORDER_X1);

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            x           <= '0;
            y           <= '0;
            px_o        <= '0;
            py_o        <= '0;
            phase       <= '0;
            ppu_tick_o  <= 1'b0;
            ce_cpu_o    <= 1'b0;
            phase_req_o <= 1'b0;
            phase_rsp_o <= 1'b0;
        end else begin
            x <= x_last ? '0 : x + 10'd1;
            if (x_last) begin
                y <= y_last ? '0 : y + 10'd1;
            end

            // ------------------------------------------------
            // Strobes all aligned with the registered tick
            ppu_tick_o  <= tick;
            ce_cpu_o    <= tick && phase == 2'd0;
            phase_req_o <= tick && phase == 2'd1;
            phase_rsp_o <= tick && phase == 2'd2;
            if (tick) begin
                phase <= (phase == ppu_pkg::CPU_DIV - 2'd1) ? '0 : phase + 2'd1;
            end

            // PPU raster restarts on the last VGA line
            if (y_last) begin
                px_o <= '0;
                py_o <= '0;
            end else if (tick) begin
                if (px_o == ppu_pkg::PPU_LINE - 9'd1) begin
                    px_o <= '0;
                    py_o <= py_o + 9'd1;
                end else begin
                    px_o <= px_o + 9'd1;
                end
            end
        end
    end

    // CPU steps only on PPU dots
    assert property (@(posedge clock25) disable iff (!reset_n)
        $rose(ce_cpu_o) |-> ppu_tick_o);

    // Line count tops out at 262 just before the raster restarts
    assert property (@(posedge clock25) disable iff (!reset_n)
        py_o <= ppu_pkg::PPU_LINES);

endmodule

// File: hw/ppu_registers.sv
module ppu_registers (
    input  logic                clock25,
    input  logic                reset_n,
    cpu_bus_if.slave            bus,
    palette_if.master           pal,
    input  logic                ppu_tick_i,
    input  logic [8:0]          px_i,
    input  logic [8:0]          py_i,
    output logic [7:0]          cpu_q_o,
    output logic                nmi_o,
    output ppu_pkg::vram_addr_t vram_a_o,
    output logic [7:0]          vram_d_o,
    output logic                vram_we_o
);

    logic [7:0]          ctrl;      // $2000
    logic [7:0]          mask;      // $2001
    logic                vblank;
    logic                w;         // Shared $2005/$2006 latch
    ppu_pkg::vram_addr_t va;        // $2006 address
    ppu_pkg::ppu_reg_e   sel;

    // $2000-$3FFF, mirrored every 8 bytes
    wire in_win  = bus.addr[15:13] == 3'b001;
    wire is_pal  = va[13:8] == 6'h3F;
    wire data_wr = in_win && sel == ppu_pkg::REG_DATA && bus.we;
    wire data_ac = in_win && sel == ppu_pkg::REG_DATA && (bus.we || bus.rd);

    assign sel = ppu_pkg::ppu_reg_e'(bus.addr[2:0]);

    // ------------------------------------------------
    // $2007 write ports, live during the request phase
    // ------------------------------------------------
    assign vram_we_o = bus.phase_req && data_wr && va[13] && !is_pal; // Nametables only
    assign vram_a_o  = va;
    assign vram_d_o  = bus.wdata;

    assign pal.we    = bus.phase_req && data_wr && is_pal;
    assign pal.idx   = va[4:0];
    assign pal.wdata = bus.wdata[5:0];

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            ctrl    <= 8'h00;
            mask    <= 8'h00;
            vblank  <= 1'b0;
            nmi_o   <= 1'b0;
            w       <= 1'b0;
            va      <= '0;
            cpu_q_o <= 8'h00;
        end else begin
            // Request phase: register writes
            if (bus.phase_req && in_win && bus.we) begin
                case (sel)
                    ppu_pkg::REG_CTRL:   ctrl <= bus.wdata;
                    ppu_pkg::REG_MASK:   mask <= bus.wdata;
                    ppu_pkg::REG_SCROLL: w    <= ~w;    // Scroll bits unused
                    ppu_pkg::REG_ADDR: begin
                        if (!w) begin
                            va[13:8] <= bus.wdata[5:0];   // High byte first
                        end else begin
                            va[7:0] <= bus.wdata;
                        end
                        w <= ~w;
                    end
                    default: ;
                endcase
            end

            // ------------------------------------------------
            // Response phase: read data and side effects
            if (bus.phase_rsp) begin
                if (bus.pad_sel) begin
                    cpu_q_o <= bus.pad_q;
                end else if (in_win && bus.rd) begin
                    case (sel)
                        ppu_pkg::REG_STATUS: begin
                            cpu_q_o <= {vblank, 7'b001_0000};
                            vblank  <= 1'b0;        // nmi_o stays up
                            w       <= 1'b0;
                        end
                        ppu_pkg::REG_DATA: begin
                            // Greyscale masks palette reads too
                            cpu_q_o <= is_pal
                                     ? {2'b00, pal.rdata & (mask[0] ? 6'h30 : 6'h3F)}
                                     : 8'h00;
                        end
                        default: ;
                    endcase
                end
                if (data_ac) begin
                    va <= va + (ctrl[2] ? 14'd32 : 14'd1);  // Across or down
                end
            end

            // Vblank window, wins over a status read on the same tick
            if (ppu_tick_i && px_i == 9'd1) begin
                if (py_i == ppu_pkg::VBL_LINE) begin
                    vblank <= 1'b1;
                    nmi_o  <= ctrl[7];
                end else if (py_i == ppu_pkg::VBL_END_LINE) begin
                    vblank <= 1'b0;
                    nmi_o  <= 1'b0;
                end
            end
        end
    end

    // One VRAM write per CPU access
    assert property (@(posedge clock25) disable iff (!reset_n)
        vram_we_o |-> bus.phase_req ##1 !vram_we_o);

endmodule

// File: hw/palette_ram.sv
module palette_ram (
    input  logic                 clock25,
    input  logic                 reset_n,
    palette_if.slave             pal,
    output ppu_pkg::color_idx_t  backdrop_o
);

    ppu_pkg::color_idx_t mem [32];

    // $3F10 aliases the backdrop on writes
    wire [4:0] widx = (pal.idx == 5'h10) ? 5'h00 : pal.idx;
    // Every colour 0 reads back as the backdrop
    wire [4:0] ridx = (pal.idx[1:0] == 2'b00) ? 5'h00 : pal.idx;

    assign pal.rdata  = mem[ridx];
    assign backdrop_o = mem[0];

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= ppu_pkg::PAL_START[i];
            end
        end else if (pal.we) begin
            mem[widx] <= pal.wdata;
        end
    end

endmodule

// File: hw/joypad_ports.sv
module joypad_ports (
    input  logic       clock25,
    input  logic       reset_n,
    cpu_bus_if.pad     bus,
    input  logic [7:0] joy1_i,
    input  logic [7:0] joy2_i
);

    logic        strobe;    // Last bit 0 written to $4016
    logic [23:0] sr1;
    logic [23:0] sr2;

    wire hit1 = bus.addr == ppu_pkg::JOY1_ADDR;
    wire hit2 = bus.addr == ppu_pkg::JOY2_ADDR;

    assign bus.pad_sel = bus.rd && (hit1 || hit2);
    assign bus.pad_q   = {7'b0100_000, hit2 ? sr2[0] : sr1[0]}; // Open bus bit 6

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            strobe <= 1'b0;
            sr1    <= '0;
            sr2    <= '0;
        end else begin
            // Falling strobe latches both pads
            if (bus.phase_req && bus.we && hit1) begin
                if (strobe && !bus.wdata[0]) begin
                    sr1 <= {16'h0800, joy1_i};
                    sr2 <= {16'h0800, joy2_i};
                end
                strobe <= bus.wdata[0];
            end

            // Shift after the bit has been read out
            if (bus.phase_rsp && bus.rd) begin
                if (hit1) begin
                    sr1 <= sr1 >> 1;
                end
                if (hit2) begin
                    sr2 <= sr2 >> 1;
                end
            end
        end
    end

endmodule

// File: hw/color_out.sv
module color_out (
    input  logic                clock25,
    input  logic                reset_n,
    input  logic                visible_i,
    input  logic                border_i,
    input  ppu_pkg::color_idx_t backdrop_i,
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o
);

    ppu_pkg::rgb_t rgb_q;
    ppu_pkg::rgb_t lut;

    assign lut = ppu_pkg::COLOR_LUT[backdrop_i];

    // ------------------------------------------------
    // Border and paper both show the backdrop
    // since no tiles are fetched
    // ------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            rgb_q <= '0;
        end else if (!visible_i) begin
            rgb_q <= '0;        // Blanking is black
        end else begin
            rgb_q <= lut;
        end
    end

    assign red_o   = rgb_q.red;
    assign green_o = rgb_q.green;
    assign blue_o  = rgb_q.blue;

    // Border decode stays inside the active picture
    assert property (@(posedge clock25) disable iff (!reset_n)
        border_i |-> visible_i);

endmodule

// File: hw/ppu_top.sv
module ppu_top (
    input  logic                clock25,
    input  logic                reset_n,
    input  logic [15:0]         cpu_a_i,
    input  logic [7:0]          cpu_d_i,
    input  logic                cpu_we_i,
    input  logic                cpu_rd_i,
    output logic [7:0]          cpu_q_o,
    output logic                ce_cpu_o,
    output logic                nmi_o,
    output ppu_pkg::vram_addr_t vram_a_o,
    output logic [7:0]          vram_d_o,
    output logic                vram_we_o,
    input  logic [7:0]          joy1_i,
    input  logic [7:0]          joy2_i,
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o
);

    cpu_bus_if bus ();
    palette_if pal ();

    logic                visible;
    logic                border;
    logic                ppu_tick;
    logic [8:0]          px;
    logic [8:0]          py;
    logic                phase_req;
    logic                phase_rsp;
    ppu_pkg::color_idx_t backdrop;

    // CPU access onto the shared bus
    assign bus.addr      = cpu_a_i;
    assign bus.wdata     = cpu_d_i;
    assign bus.we        = cpu_we_i;
    assign bus.rd        = cpu_rd_i;
    assign bus.phase_req = phase_req;
    assign bus.phase_rsp = phase_rsp;

    beam_timing i_beam (
        .clock25(clock25), .reset_n(reset_n),
        .hsync_o(hsync_o), .vsync_o(vsync_o),
        .visible_o(visible), .border_o(border),
        .ppu_tick_o(ppu_tick), .px_o(px), .py_o(py),
        .ce_cpu_o(ce_cpu_o), .phase_req_o(phase_req), .phase_rsp_o(phase_rsp)
    );

    ppu_registers i_regs (
        .clock25(clock25), .reset_n(reset_n), .bus(bus.slave), .pal(pal.master),
        .ppu_tick_i(ppu_tick), .px_i(px), .py_i(py),
        .cpu_q_o(cpu_q_o), .nmi_o(nmi_o),
        .vram_a_o(vram_a_o), .vram_d_o(vram_d_o), .vram_we_o(vram_we_o)
    );

    palette_ram i_pal (
        .clock25(clock25), .reset_n(reset_n), .pal(pal.slave), .backdrop_o(backdrop)
    );

    joypad_ports i_joy (
        .clock25(clock25), .reset_n(reset_n), .bus(bus.pad),
        .joy1_i(joy1_i), .joy2_i(joy2_i)
    );

    color_out i_color (
        .clock25(clock25), .reset_n(reset_n),
        .visible_i(visible), .border_i(border), .backdrop_i(backdrop),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o)
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock (
    output logic clock_o,
    output logic reset_n_o
);

    // 100 time unit period
    initial begin
        clock_o = 1'b0;
        forever #50 clock_o = ~clock_o;
    end

    initial begin
        reset_n_o = 1'b0;               // Held for two rising edges
        repeat (2) @(posedge clock_o);
        #10 reset_n_o = 1'b1;
    end

endmodule

// File: bench/tb_ppu_top.sv
module tb_ppu_top;

    localparam longint FRAME = 64'd420000;     // 800 x 525 clocks

    logic        clock25;
    logic        reset_n;
    logic [15:0] cpu_a;
    logic [7:0]  cpu_d;
    logic        cpu_we;
    logic        cpu_rd;
    logic [7:0]  joy1;
    logic [7:0]  joy2;
    logic [7:0]  cpu_q;
    logic        ce_cpu;
    logic        nmi;
    logic [13:0] vram_a;
    logic [7:0]  vram_d;
    logic        vram_we;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hsync;
    logic        vsync;

    longint      clk_count = 0;
    int          checks = 0;
    int          fails = 0;
    int          test_fails = 0;
    logic [31:0] lfsr = 32'h7d170e33;
    logic [13:0] va_q [$];              // Captured VRAM writes
    logic [7:0]  vd_q [$];

    // Palette rows give write entry, read entry and expected read
    typedef struct packed {
        logic [4:0] widx;
        logic [7:0] wdata;
        logic [4:0] ridx;
        logic [7:0] exp;
    } pal_row_t;

    pal_row_t pal_tab [6] = '{
        '{5'h01, 8'h21, 5'h01, 8'h21},
        '{5'h10, 8'h05, 5'h00, 8'h05},  // $3F10 lands in entry 0
        '{5'h13, 8'hFF, 5'h13, 8'h3F},  // Six bits stored
        '{5'h04, 8'h11, 5'h14, 8'h05},  // Colour 0 reads backdrop
        '{5'h00, 8'h2A, 5'h0C, 8'h2A},
        '{5'h1E, 8'h16, 5'h1E, 8'h16}
    };

    // VRAM rows give CPU write, expected pulse and expected address
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        pulse;
        logic [13:0] exp_a;
    } vram_row_t;

    vram_row_t vram_tab [10] = '{
        '{16'h2006, 8'h21, 1'b0, 14'h0000},
        '{16'h2006, 8'h05, 1'b0, 14'h0000},
        '{16'h2007, 8'hA5, 1'b1, 14'h2105},
        '{16'h2007, 8'h5A, 1'b1, 14'h2106},
        '{16'h2000, 8'h04, 1'b0, 14'h0000},  // Increment by 32
        '{16'h2007, 8'h3C, 1'b1, 14'h2107},
        '{16'h2007, 8'hC3, 1'b1, 14'h2127},
        '{16'h2006, 8'h10, 1'b0, 14'h0000},
        '{16'h2006, 8'h00, 1'b0, 14'h0000},
        '{16'h2007, 8'h77, 1'b0, 14'h0000}   // Pattern space gets no pulse
    };

    // Reference colour table with 4 bits per gun
    logic [11:0] rgb_ref [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

    tb_clock i_clk (.clock_o(clock25), .reset_n_o(reset_n));

    ppu_top i_dut (
        .clock25(clock25), .reset_n(reset_n),
        .cpu_a_i(cpu_a), .cpu_d_i(cpu_d), .cpu_we_i(cpu_we), .cpu_rd_i(cpu_rd),
        .cpu_q_o(cpu_q), .ce_cpu_o(ce_cpu), .nmi_o(nmi),
        .vram_a_o(vram_a), .vram_d_o(vram_d), .vram_we_o(vram_we),
        .joy1_i(joy1), .joy2_i(joy2),
        .red_o(red), .green_o(green), .blue_o(blue),
        .hsync_o(hsync), .vsync_o(vsync)
    );

    always @(posedge clock25) clk_count <= clk_count + 1;

    // VRAM write monitor
    always @(posedge clock25) begin
        #1;
        if (vram_we) begin
            va_q.push_back(vram_a);
            vd_q.push_back(vram_d);
        end
    end

    // Watchdog over three frames
    initial begin
        #(3 * FRAME * 100);
        $display("Timeout: the run did not finish within three frames");
        $display("TEST FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic take_bit();     // Fibonacci LFSR with taps 32 22 2 1
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic step();                   // Sample point after the edge
        @(posedge clock25);
        #1;
    endtask

    task automatic wait_ce();
        do step(); while (!ce_cpu);
    endtask

    task automatic bus_access(input logic [15:0] a, input logic [7:0] d,
                              input logic wr, output logic [7:0] q);
        wait_ce();
        #9;                                  // 10 after the edge
        cpu_a  = a;
        cpu_d  = d;
        cpu_we = wr;
        cpu_rd = !wr;
        wait_ce();                           // Result ready here
        q = cpu_q;
        #9;
        cpu_we = 1'b0;
        cpu_rd = 1'b0;
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] unused;
        bus_access(a, d, 1'b1, unused);
    endtask

    task automatic cpu_read(input logic [15:0] a, output logic [7:0] q);
        bus_access(a, 8'h00, 1'b0, q);
    endtask

    task automatic set_vaddr(input logic [13:0] a);  // High byte first
        cpu_write(16'h2006, {2'b00, a[13:8]});
        cpu_write(16'h2006, a[7:0]);
    endtask

    task automatic check(input string name, input logic [15:0] got,
                         input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            fails++;
            test_fails++;
        end
    endtask

    task automatic report(input string what);
        $display("At %0t: %s", $time, what);
        fails++;
        test_fails++;
    endtask

    task automatic finish_test(input int n, input string title);
        $display("Test %0d %s: %s", n, title, (test_fails == 0) ? "ok" : "failed");
        test_fails = 0;
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        longint     frame_start;
        longint     target;
        int         n;
        logic       nmi_quiet;
        logic [7:0] q;
        logic [7:0] pad1;
        logic [7:0] pad2;

        cpu_a  = 16'h0000;
        cpu_d  = 8'h00;
        cpu_we = 1'b0;
        cpu_rd = 1'b0;
        joy1   = 8'h00;
        joy2   = 8'h00;
        nmi_quiet = 1'b1;

        // Test 1 checks reset state and sync timing
        wait (reset_n);
        step();
        check("nmi_o", nmi, 1'b0);
        check("vram_we_o", vram_we, 1'b0);
        check("ce_cpu_o", ce_cpu, 1'b0);
        wait_ce();                           // First CPU enable on line 1
        n = 0;
        do begin
            step();
            n++;
        end while (!ce_cpu);
        check("ce_cpu_o period clocks", n, 6);  // Three dots of two clocks
        while (hsync) step();
        n = 0;
        while (!hsync) begin
            step();
            n++;
        end
        check("hsync_o low clocks", n, 96);
        while (hsync) begin
            step();
            n++;
        end
        check("line clocks", n, 800);
        while (vsync) begin                  // Whole frame with ctrl bit 7 clear
            step();
            if (nmi) nmi_quiet = 1'b0;
        end
        n = 0;
        while (!vsync) begin
            step();
            n++;
            if (nmi) nmi_quiet = 1'b0;
        end
        check("vsync_o low clocks", n, 1600);
        frame_start = clk_count;             // Beam at x 0, y 0
        finish_test(1, "reset and sync");

        // Test 2 runs the palette through $2006/$2007
        for (int i = 0; i < 6; i++) begin
            set_vaddr({9'h1F8, pal_tab[i].widx});
            cpu_write(16'h2007, pal_tab[i].wdata);
            set_vaddr({9'h1F8, pal_tab[i].ridx});
            cpu_read(16'h2007, q);
            check("cpu_q_o", q, pal_tab[i].exp);
        end
        finish_test(2, "palette");

        // Test 3 covers the VRAM write port
        for (int i = 0; i < 10; i++) begin
            cpu_write(vram_tab[i].addr, vram_tab[i].data);
            if (vram_tab[i].pulse) begin
                check("vram_we_o pulses", va_q.size(), 1);
                if (va_q.size() > 0) begin
                    check("vram_a_o", va_q[0], vram_tab[i].exp_a);
                    check("vram_d_o", vd_q[0], vram_tab[i].data);
                end
            end else begin
                check("vram_we_o pulses", va_q.size(), 0);
            end
            va_q.delete();
            vd_q.delete();
        end
        finish_test(3, "vram writes");

        // Test 4 shows the backdrop colour on screen
        set_vaddr(14'h3F00);
        cpu_write(16'h2007, 8'h16);          // Differs from the entry left by test 2
        target = frame_start + 273 * 800 + 368;  // Screen centre
        while (target <= clk_count) target += FRAME;
        while (clk_count < target) step();
        check("rgb centre", {red, green, blue}, rgb_ref[6'h16]);
        while (hsync) step();
        check("rgb in hsync", {red, green, blue}, 12'h000);
        finish_test(4, "backdrop");

        // Test 5 reads both joypads with LFSR buttons
        step();
        #9;
        for (int i = 0; i < 8; i++) pad1[i] = take_bit();
        for (int i = 0; i < 8; i++) pad2[i] = take_bit();
        joy1 = pad1;
        joy2 = pad2;
        cpu_write(16'h4016, 8'h01);
        cpu_write(16'h4016, 8'h00);          // Falling strobe latches
        for (int i = 0; i < 8; i++) begin
            cpu_read(16'h4016, q);
            check("cpu_q_o joy1", q, {7'b0100_000, pad1[i]});
        end
        for (int i = 0; i < 8; i++) begin
            cpu_read(16'h4017, q);
            check("cpu_q_o joy2", q, {7'b0100_000, pad2[i]});
        end
        finish_test(5, "joypads");

        // Test 6 covers vblank and NMI
        if (!nmi_quiet) report("nmi_o rose while ctrl bit 7 was clear");
        cpu_write(16'h2000, 8'h80);
        n = 0;
        while (!nmi && n < FRAME) begin
            step();
            n++;
        end
        if (!nmi) report("nmi_o did not rise within one frame");
        cpu_read(16'h2002, q);
        check("status bit 7", q[7], 1'b1);
        cpu_read(16'h2002, q);               // Cleared by the first read
        check("status bit 7", q[7], 1'b0);
        finish_test(6, "vblank and nmi");

        $display("Checks run: %0d, failed: %0d", checks, fails);
        if (fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: ppu_top.f
hw/ppu_pkg.sv
hw/cpu_bus_if.sv
hw/palette_if.sv
hw/beam_timing.sv
hw/ppu_registers.sv
hw/palette_ram.sv
hw/joypad_ports.sv
hw/color_out.sv
hw/ppu_top.sv
bench/tb_clock.sv
bench/tb_ppu_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ppu_top
FLIST     ?= ppu_top.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
